// File: hw/rtu_pkg.sv
// modbus rtu transmit definitions
package rtu_pkg;

	localparam int MAX_PDU_SIZE = 16;	// pdu bytes in the buffer
	localparam int FRAME_OVERHEAD = 3;	// address + crc lo + crc hi
	localparam int PTR_WIDTH = 5;	// frame index 0 .. size + 2
	localparam logic [7:0] MAX_SLAVE_ADDR = 8'd247;	// 0 is broadcast, still valid

	localparam int BAUD_DIV_9600 = 16;	// clocks per bit
	localparam int BAUD_DIV_19200 = 8;
	localparam int BAUD_DIV_OPT1 = 4;
	localparam int BAUD_DIV_OPT2 = 2;
	localparam int BDWIDTH = $clog2(BAUD_DIV_9600 + 1);

	localparam int CHAR_BITS_X2 = 42;	// 12 bits/char * 3.5 chars
	localparam int SILENCE_WIDTH = $clog2(BAUD_DIV_9600 * CHAR_BITS_X2 + 1);
	localparam int DE_TIME = 10;	// driver settle, clocks

	localparam logic [15:0] CRC_INIT = 16'hffff;
	localparam logic [15:0] CRC_POLY = 16'ha001;	// reflected 0x8005

	localparam logic [1:0] REG_PDU_SIZE = 2'd0;
	localparam logic [1:0] REG_CONFIG = 2'd1;
	localparam logic [1:0] REG_SLAVE_ADDR = 2'd2;
	localparam logic [1:0] REG_CONTROL = 2'd3;

	typedef struct packed {
		logic [1:0] baud_code;	// 0 9600, 1 19200, 2 opt1, 3 opt2
		logic parity_ena;
		logic parity_odd;	// 0 even
		logic two_stop;
	} line_cfg_t;

	localparam line_cfg_t CONFIG_DEFAULT = '{
		baud_code: 2'd1,
		parity_ena: 1'b1,
		parity_odd: 1'b0,
		two_stop: 1'b0
	};
	localparam logic [7:0] ADDR_DEFAULT = 8'd1;

	// host write word, config layout or plain byte
	typedef union packed {
		struct packed {
			logic [20:0] pad_hi;
			logic two_stop;	// bit 10
			logic parity_odd;	// bit 9
			logic parity_ena;	// bit 8
			logic [5:0] pad_lo;
			logic [1:0] baud_code;	// bits 1:0
		} cfg;
		struct packed {
			logic [23:0] pad;	// must be zero for a valid value
			logic [7:0] value;
		} val;
	} cs_word_u;

	typedef enum logic {
		SEL_DRIVER,
		SEL_SILENCE
	} timer_sel_t;

	function automatic logic [BDWIDTH-1:0] baud_div(input logic [1:0] code);
		case (code)
			2'd0: return BDWIDTH'(BAUD_DIV_9600);
			2'd2: return BDWIDTH'(BAUD_DIV_OPT1);
			2'd3: return BDWIDTH'(BAUD_DIV_OPT2);
			default: return BDWIDTH'(BAUD_DIV_19200);
		endcase
	endfunction

endpackage

// File: hw/rtu_regs.sv
// host register file
`timescale 1ns/1ps
module rtu_regs (
	input logic clk,
	input logic reset,
	input logic [1:0] cs_addr,
	input logic cs_wr,
	input rtu_pkg::cs_word_u cs_wrd,
	input logic ready,
	output logic [31:0] cs_rdd,
	output rtu_pkg::line_cfg_t cfg,
	output logic [7:0] slave_addr,
	output logic [rtu_pkg::PTR_WIDTH-1:0] pdu_size,
	output logic send_req
);
	import rtu_pkg::*;

	logic wr_ok;	// writes only land while idle
	logic size_ok;
	logic addr_ok;
	cs_word_u rd_word;

	assign wr_ok = cs_wr && ready;
	assign size_ok = (cs_wrd.val.pad == '0) && (cs_wrd.val.value != 8'd0) &&
		(cs_wrd.val.value <= MAX_PDU_SIZE);	// 1 .. 16
	assign addr_ok = (cs_wrd.val.pad == '0) && (cs_wrd.val.value <= MAX_SLAVE_ADDR);
	assign send_req = wr_ok && (cs_addr == REG_CONTROL);	// data bits ignored

	always_ff @(posedge clk) begin
		if (reset) begin
			pdu_size <= PTR_WIDTH'(1);
			cfg <= CONFIG_DEFAULT;
			slave_addr <= ADDR_DEFAULT;
		end else if (wr_ok) begin
			if (cs_addr == REG_PDU_SIZE && size_ok)
				pdu_size <= PTR_WIDTH'(cs_wrd.val.value);
			if (cs_addr == REG_CONFIG) begin
				cfg.baud_code <= cs_wrd.cfg.baud_code;
				cfg.parity_ena <= cs_wrd.cfg.parity_ena;
				cfg.parity_odd <= cs_wrd.cfg.parity_odd;
				cfg.two_stop <= cs_wrd.cfg.two_stop;
			end
			if (cs_addr == REG_SLAVE_ADDR && addr_ok)
				slave_addr <= cs_wrd.val.value;
		end
	end

	always_comb begin
		rd_word = '0;
		case (cs_addr)
			REG_PDU_SIZE: rd_word.val.value = 8'(pdu_size);
			REG_CONFIG: begin
				rd_word.cfg.baud_code = cfg.baud_code;	// same layout as written
				rd_word.cfg.parity_ena = cfg.parity_ena;
				rd_word.cfg.parity_odd = cfg.parity_odd;
				rd_word.cfg.two_stop = cfg.two_stop;
			end
			REG_SLAVE_ADDR: rd_word.val.value = slave_addr;
			default: rd_word.val.value = {7'd0, ready};	// status, bit 0
		endcase
		cs_rdd = rd_word;
	end

endmodule

// File: hw/frame_buffer.sv
// frame byte store and transmit pointer
`timescale 1ns/1ps
module frame_buffer (
	input logic clk,
	input logic reset,
	input logic [1:0] pdu_addr,
	input logic pdu_wr,
	input logic [31:0] pdu_wrd,
	input logic [7:0] slave_addr,
	input logic [rtu_pkg::PTR_WIDTH-1:0] pdu_size,
	input logic crc_store,
	input logic [15:0] crc,
	input logic byte_next,
	input logic [rtu_pkg::PTR_WIDTH-1:0] crc_index,
	input logic ready,
	output logic [31:0] pdu_rdd,
	output logic [7:0] crc_byte,
	output logic [7:0] tx_byte,
	output logic last_byte
);
	import rtu_pkg::*;

	logic [MAX_PDU_SIZE/4-1:0][31:0] pdu_mem;	// four bytes per word, byte 0 low
	logic [15:0] crc_reg;
	logic [PTR_WIDTH-1:0] ptr;

	// frame view: addr, pdu, crc lo, crc hi
	function automatic logic [7:0] frame_byte(input logic [PTR_WIDTH-1:0] idx);
		logic [PTR_WIDTH-1:0] j;
		j = idx - 1'b1;	// pdu offset
		if (idx == '0)
			return slave_addr;
		else if (idx <= pdu_size)
			return pdu_mem[j[3:2]][8*j[1:0] +: 8];
		else if (idx == pdu_size + 1)
			return crc_reg[7:0];
		else
			return crc_reg[15:8];
	endfunction

	always_ff @(posedge clk) begin
		if (pdu_wr && ready)	// host locked out while busy
			pdu_mem[pdu_addr] <= pdu_wrd;
		if (crc_store)
			crc_reg <= crc;
	end

	always_ff @(posedge clk) begin
		if (reset || ready)
			ptr <= '0;	// rewinds before each frame
		else if (byte_next)
			ptr <= ptr + 1'b1;
	end

	assign pdu_rdd = pdu_mem[pdu_addr];
	assign last_byte = (ptr == pdu_size + 2);	// crc hi

	always_comb begin
		crc_byte = frame_byte(crc_index);
	end

	always_comb begin
		tx_byte = frame_byte(ptr);
	end

endmodule

// File: hw/crc16_engine.sv
// bit-serial modbus crc-16
`timescale 1ns/1ps
module crc16_engine (
	input logic clk,
	input logic reset,
	input logic crc_start,
	input logic [rtu_pkg::PTR_WIDTH-1:0] pdu_size,
	input logic [7:0] crc_byte,
	output logic [rtu_pkg::PTR_WIDTH-1:0] crc_index,
	output logic crc_done,
	output logic [15:0] crc
);
	import rtu_pkg::*;

	logic busy;
	logic [2:0] bit_cnt;	// lsb first within a byte
	logic feedback;
	logic last_bit;

	assign feedback = crc[0] ^ crc_byte[bit_cnt];
	assign last_bit = (crc_index == pdu_size) && (bit_cnt == 3'd7);	// addr + pdu done

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			crc_done <= 1'b0;
			crc_index <= '0;
			bit_cnt <= '0;
		end else begin
			crc_done <= busy && last_bit;
			if (crc_start) begin
				busy <= 1'b1;
				crc_index <= '0;	// start at address byte
				bit_cnt <= '0;
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;	// wraps to 0 per byte
				if (bit_cnt == 3'd7)
					crc_index <= crc_index + 1'b1;
				if (last_bit)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (crc_start)
			crc <= CRC_INIT;
		else if (busy)
			crc <= {1'b0, crc[15:1]} ^ (feedback ? CRC_POLY : 16'h0000);
	end

endmodule

// File: hw/rtu_timer.sv
// driver settle and t3.5 timer
`timescale 1ns/1ps
module rtu_timer (
	input logic clk,
	input logic reset,
	input logic timer_run,
	input rtu_pkg::timer_sel_t timer_sel,
	input rtu_pkg::line_cfg_t cfg,
	output logic expired
);
	import rtu_pkg::*;

	logic [SILENCE_WIDTH-1:0] count;
	logic [SILENCE_WIDTH-1:0] limit;

	always_comb begin
		if (timer_sel == SEL_DRIVER)
			limit = SILENCE_WIDTH'(DE_TIME);
		else
			limit = SILENCE_WIDTH'(baud_div(cfg.baud_code) * CHAR_BITS_X2);	// 3.5 chars
	end

	always_ff @(posedge clk) begin
		if (reset || !timer_run)
			count <= '0;	// held clear between intervals
		else
			count <= count + 1'b1;
	end

	assign expired = (count == limit);

endmodule

// File: hw/rtu_master_fsm.sv
// master transmit sequencer
`timescale 1ns/1ps
module rtu_master_fsm (
	input logic clk,
	input logic reset,
	input logic send_req,
	input logic crc_done,
	input logic expired,
	input logic tx_ready,
	input logic last_byte,
	output logic ready,
	output logic oe,
	output logic crc_start,
	output logic crc_store,
	output logic timer_run,
	output rtu_pkg::timer_sel_t timer_sel,
	output logic tx_valid,
	output logic byte_next
);
	import rtu_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		CRC_GEN,
		DRIVER_ON,
		SEND,
		SILENCE
	} state_t;

	state_t state;
	state_t state_next;
	logic all_sent;	// crc hi handed to the uart

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (send_req) state_next = CRC_GEN;
			CRC_GEN: if (crc_done) state_next = DRIVER_ON;
			DRIVER_ON: if (expired) state_next = SEND;	// first char goes now
			SEND: if (all_sent && tx_ready) state_next = SILENCE;	// last stop bit ends
			SILENCE: if (expired) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			crc_start <= 1'b0;
			all_sent <= 1'b0;
		end else begin
			state <= state_next;
			crc_start <= (state == IDLE) && send_req;	// one cycle after request
			if (byte_next && last_byte)
				all_sent <= 1'b1;
			else if (state == IDLE)
				all_sent <= 1'b0;
		end
	end

	assign ready = (state == IDLE);
	assign oe = (state == DRIVER_ON) || (state == SEND);
	assign crc_store = (state == CRC_GEN) && crc_done;
	assign timer_run = (state == DRIVER_ON) || (state == SILENCE);
	assign timer_sel = (state == SILENCE) ? SEL_SILENCE : SEL_DRIVER;
	assign tx_valid = ((state == SEND) && !all_sent) || ((state == DRIVER_ON) && expired);
	assign byte_next = tx_valid && tx_ready;	// char accepted

endmodule

// File: hw/uart_tx.sv
// uart character transmitter
`timescale 1ns/1ps
module uart_tx (
	input logic clk,
	input logic reset,
	input rtu_pkg::line_cfg_t cfg,
	input logic [7:0] tx_byte,
	input logic tx_valid,
	output logic tx_ready,
	output logic txd
);
	import rtu_pkg::*;

	logic busy;
	logic [11:0] shift;	// start, data, parity/stop, stop
	logic [3:0] bit_cnt;
	logic [BDWIDTH-1:0] div_cnt;
	logic [BDWIDTH-1:0] divisor;
	logic [3:0] char_bits;	// 10 .. 12
	logic parity_bit;
	logic bit_end;
	logic char_end;
	logic load;

	assign divisor = baud_div(cfg.baud_code);
	assign char_bits = 4'd10 + 4'(cfg.parity_ena) + 4'(cfg.two_stop);
	assign parity_bit = (^tx_byte) ^ cfg.parity_odd;	// even makes total ones even
	assign bit_end = (div_cnt == divisor - 1'b1);
	assign char_end = busy && bit_end && (bit_cnt == char_bits - 1'b1);
	assign tx_ready = !busy || char_end;	// back to back on the last stop clock
	assign load = tx_valid && tx_ready;
	assign txd = busy ? shift[0] : 1'b1;	// line idles high

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (load) begin
			busy <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (char_end) begin
			busy <= 1'b0;
		end else if (busy) begin
			if (bit_end) begin
				div_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			shift <= {2'b11, cfg.parity_ena ? parity_bit : 1'b1, tx_byte, 1'b0};
		else if (busy && bit_end)
			shift <= {1'b1, shift[11:1]};	// fill with stop level
	end

endmodule

// File: hw/rtu_tx_master.sv
// modbus rtu transmit master
`timescale 1ns/1ps
module rtu_tx_master (
	input logic clk,
	input logic reset,
	input logic [1:0] cs_addr,
	input logic cs_wr,
	input logic [31:0] cs_wrd,
	output logic [31:0] cs_rdd,
	input logic [1:0] pdu_addr,
	input logic pdu_wr,
	input logic [31:0] pdu_wrd,
	output logic [31:0] pdu_rdd,
	output logic txd,
	output logic oe
);
	import rtu_pkg::*;

	line_cfg_t cfg;
	logic [7:0] slave_addr;
	logic [PTR_WIDTH-1:0] pdu_size;
	logic send_req;
	logic ready;	// also seen by the bound checks
	logic crc_start;
	logic crc_done;
	logic crc_store;
	logic [15:0] crc;
	logic [PTR_WIDTH-1:0] crc_index;
	logic [7:0] crc_byte;
	logic timer_run;
	timer_sel_t timer_sel;
	logic expired;
	logic tx_valid;
	logic tx_ready;
	logic byte_next;
	logic last_byte;
	logic [7:0] tx_byte;

	rtu_regs regs_inst (
		.clk(clk), .reset(reset),
		.cs_addr(cs_addr), .cs_wr(cs_wr), .cs_wrd(cs_wrd),	// raw word into union port
		.ready(ready), .cs_rdd(cs_rdd), .cfg(cfg),
		.slave_addr(slave_addr), .pdu_size(pdu_size), .send_req(send_req)
	);

	frame_buffer buf_inst (
		.clk(clk), .reset(reset),
		.pdu_addr(pdu_addr), .pdu_wr(pdu_wr), .pdu_wrd(pdu_wrd),
		.slave_addr(slave_addr), .pdu_size(pdu_size),
		.crc_store(crc_store), .crc(crc), .byte_next(byte_next),
		.crc_index(crc_index), .ready(ready), .pdu_rdd(pdu_rdd),
		.crc_byte(crc_byte), .tx_byte(tx_byte), .last_byte(last_byte)
	);

	crc16_engine crc_inst (
		.clk(clk), .reset(reset), .crc_start(crc_start), .pdu_size(pdu_size),
		.crc_byte(crc_byte), .crc_index(crc_index), .crc_done(crc_done), .crc(crc)
	);

	rtu_timer timer_inst (
		.clk(clk), .reset(reset), .timer_run(timer_run),
		.timer_sel(timer_sel), .cfg(cfg), .expired(expired)
	);

	rtu_master_fsm fsm_inst (
		.clk(clk), .reset(reset), .send_req(send_req), .crc_done(crc_done),
		.expired(expired), .tx_ready(tx_ready), .last_byte(last_byte),
		.ready(ready), .oe(oe), .crc_start(crc_start), .crc_store(crc_store),
		.timer_run(timer_run), .timer_sel(timer_sel),
		.tx_valid(tx_valid), .byte_next(byte_next)
	);

	uart_tx uart_inst (
		.clk(clk), .reset(reset), .cfg(cfg), .tx_byte(tx_byte),
		.tx_valid(tx_valid), .tx_ready(tx_ready), .txd(txd)
	);

endmodule

// File: sim/rtu_tx_master_properties.sv
// line and ready checks
`timescale 1ns/1ps
module rtu_tx_master_properties (
	input logic clk,
	input logic reset,
	input logic ready,
	input logic oe,
	input logic txd
);
	import rtu_pkg::*;

	localparam int SETTLE_CYCLES = DE_TIME + 1;	// oe rise to first start bit

	int fail_count = 0;	// property failures so far

	idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> ready && !oe)
		else begin
			fail_count++;
			$error("ready low or oe high right after reset");
		end

	line_idle_when_off: assert property (@(posedge clk) disable iff (reset) !oe |-> txd)
		else begin
			fail_count++;
			$error("txd low while oe is low");
		end

	busy_while_driving: assert property (@(posedge clk) disable iff (reset) oe |-> !ready)
		else begin
			fail_count++;
			$error("ready high while oe is high");
		end

	// driver settles before any start bit
	settle_before_start: assert property (@(posedge clk) disable iff (reset)
		$rose(oe) |-> txd [*SETTLE_CYCLES])
		else begin
			fail_count++;
			$error("start bit inside the driver settle time");
		end

endmodule

bind rtu_tx_master rtu_tx_master_properties props (
	.clk(clk), .reset(reset), .ready(ready), .oe(oe), .txd(txd)
);

// File: sim/rtu_tx_master_tb.sv
// modbus rtu transmit testbench
`timescale 1ns/1ps
module rtu_tx_master_tb;
	import rtu_pkg::*;

	localparam int WAIT_LIMIT = 2000;	// clocks per wait loop

	logic clk = 1'b0;
	logic reset;
	logic [1:0] cs_addr;
	logic cs_wr;
	logic [31:0] cs_wrd;
	logic [31:0] cs_rdd;
	logic [1:0] pdu_addr;
	logic pdu_wr;
	logic [31:0] pdu_wrd;
	logic [31:0] pdu_rdd;
	logic txd;
	logic oe;

	int cycle = 0;	// posedge count for timing
	int seed;
	logic [7:0] pdu_bytes [MAX_PDU_SIZE];	// expected pdu contents
	logic [1:0] cur_code;	// line setup the DUT should hold
	logic cur_ena;
	logic cur_odd;
	logic cur_two;
	int cur_div;
	logic [7:0] cur_addr;
	int cur_size;

	rtu_tx_master dut (
		.clk(clk), .reset(reset),
		.cs_addr(cs_addr), .cs_wr(cs_wr), .cs_wrd(cs_wrd), .cs_rdd(cs_rdd),
		.pdu_addr(pdu_addr), .pdu_wr(pdu_wr), .pdu_wrd(pdu_wrd), .pdu_rdd(pdu_rdd),
		.txd(txd), .oe(oe)
	);

	always #10 clk = ~clk;	// 20 ns period

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	always @(dut.props.fail_count) begin
		if (dut.props.fail_count != 0)
			abort_run("a bound line property failed");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
			else abort_run($sformatf("[FAIL] %0t ns %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
	endtask

	function automatic int bit_clocks(input logic [1:0] code);
		case (code)
			2'd0: return BAUD_DIV_9600;
			2'd2: return BAUD_DIV_OPT1;
			2'd3: return BAUD_DIV_OPT2;
			default: return BAUD_DIV_19200;
		endcase
	endfunction

	function automatic logic [31:0] config_word(input logic [1:0] code, input logic ena,
		input logic odd, input logic two);
		return {21'd0, two, odd, ena, 6'd0, code};	// flags in 10:8
	endfunction

	// reference crc over address and pdu bytes with poly a001
	function automatic logic [15:0] modbus_crc(input logic [7:0] addr, input int n);
		logic [15:0] c;
		logic [7:0] b;
		int i;
		int k;
		c = 16'hffff;
		for (i = 0; i <= n; i++) begin
			b = (i == 0) ? addr : pdu_bytes[i-1];
			c = c ^ {8'h00, b};
			for (k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
		end
		return c;
	endfunction

	task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		cs_addr = addr;
		cs_wrd = data;
		cs_wr = 1'b1;
		@(posedge clk);
		#2;
		cs_wr = 1'b0;
	endtask

	task automatic pdu_write(input logic [1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		pdu_addr = addr;
		pdu_wrd = data;
		pdu_wr = 1'b1;
		@(posedge clk);
		#2;
		pdu_wr = 1'b0;
	endtask

	task automatic read_check(input logic [1:0] addr, input logic [31:0] exp,
		input string name);
		@(posedge clk);
		#2;
		cs_addr = addr;
		@(negedge clk);	// combinational read settled
		check_value(name, cs_rdd, exp);
	endtask

	task automatic set_config(input logic [1:0] code, input logic ena, input logic odd,
		input logic two);
		reg_write(REG_CONFIG, config_word(code, ena, odd, two));
		cur_code = code;
		cur_ena = ena;
		cur_odd = odd;
		cur_two = two;
		cur_div = bit_clocks(code);
	endtask

	task automatic set_size(input int n);
		reg_write(REG_PDU_SIZE, 32'(n));
		cur_size = n;
	endtask

	task automatic set_addr(input logic [7:0] a);
		reg_write(REG_SLAVE_ADDR, {24'd0, a});
		cur_addr = a;
	endtask

	task automatic load_pdu();
		logic [31:0] word;
		int i;
		for (i = 0; i < MAX_PDU_SIZE; i++)
			pdu_bytes[i] = 8'($random(seed));
		for (i = 0; i < MAX_PDU_SIZE / 4; i++) begin
			word = {pdu_bytes[4*i+3], pdu_bytes[4*i+2], pdu_bytes[4*i+1], pdu_bytes[4*i]};
			pdu_write(2'(i), word);
			@(negedge clk);
			check_value("pdu_rdd", pdu_rdd, word);	// byte 0 in the low lane
		end
	endtask

	// mid-bit sampling of one character
	task automatic decode_char(output logic [7:0] data, output int start_cyc);
		int wait_cnt;
		int i;
		wait_cnt = 0;
		do begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				abort_run("timeout: no start bit seen on txd");
		end while (txd !== 1'b0);
		start_cyc = cycle;
		repeat (cur_div / 2) @(negedge clk);
		check_value("txd start bit", txd, 0);
		for (i = 0; i < 8; i++) begin
			repeat (cur_div) @(negedge clk);
			data[i] = txd;	// lsb first
		end
		if (cur_ena) begin
			repeat (cur_div) @(negedge clk);
			check_value("txd parity", $countones({data, txd}) % 2, cur_odd);	// total ones
		end
		repeat (cur_div) @(negedge clk);
		check_value("txd stop bit", txd, 1);
		if (cur_two) begin
			repeat (cur_div) @(negedge clk);
			check_value("txd second stop bit", txd, 1);
		end
	endtask

	task automatic send_frame(input logic busy_writes);
		logic [7:0] expect_q [$];
		logic [7:0] got;
		logic [15:0] crc;
		int req_cyc;
		int oe_cyc;
		int start_cyc;
		int prev_start;
		int wait_cnt;
		int char_cycles;
		int i;
		crc = modbus_crc(cur_addr, cur_size);
		expect_q.push_back(cur_addr);
		for (i = 0; i < cur_size; i++)
			expect_q.push_back(pdu_bytes[i]);
		expect_q.push_back(crc[7:0]);	// crc low byte first
		expect_q.push_back(crc[15:8]);
		char_cycles = (10 + cur_ena + cur_two) * cur_div;
		@(posedge clk);
		#2;
		cs_addr = REG_CONTROL;
		cs_wrd = '0;
		cs_wr = 1'b1;
		req_cyc = cycle;
		@(posedge clk);
		#2;
		cs_wr = 1'b0;
		if (busy_writes) begin	// all land during crc_gen
			reg_write(REG_PDU_SIZE, 32'd2);
			reg_write(REG_CONFIG, config_word(2'd0, 1'b0, 1'b0, 1'b1));
			reg_write(REG_SLAVE_ADDR, 32'd9);
			pdu_write(2'd0, 32'h1234_5678);
			reg_write(REG_CONTROL, 32'd0);
		end
		wait_cnt = 0;
		while (oe !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				abort_run("timeout: oe did not rise after the send request");
		end
		oe_cyc = cycle;
		check_value("send_req to oe cycles", oe_cyc - req_cyc, 8 * (cur_size + 1) + 3);
		prev_start = 0;
		for (i = 0; i < expect_q.size(); i++) begin
			decode_char(got, start_cyc);
			check_value($sformatf("txd frame byte %0d", i), got, expect_q[i]);
			if (i == 0)
				check_value("oe to first start cycles", start_cyc - oe_cyc, DE_TIME + 1);
			else
				check_value("character cycles", start_cyc - prev_start, char_cycles);
			prev_start = start_cyc;
		end
		wait_cnt = 0;
		while (oe !== 1'b0) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				abort_run("timeout: oe stayed high after the last character");
		end
		check_value("last start to oe fall", cycle - prev_start, char_cycles);
		oe_cyc = cycle;	// now the fall cycle
		wait_cnt = 0;
		while (cs_rdd[0] !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				abort_run("timeout: ready did not return after the silent interval");
		end
		check_value("oe fall to ready cycles", cycle - oe_cyc, cur_div * CHAR_BITS_X2 + 1);
		if (busy_writes) begin
			repeat (100) begin	// a second frame would start well inside this
				@(negedge clk);
				check_value("oe after busy frame", oe, 0);
			end
			read_check(REG_PDU_SIZE, 32'(cur_size), "pdu_size after busy writes");
			read_check(REG_SLAVE_ADDR, {24'd0, cur_addr}, "slave_addr after busy writes");
			read_check(REG_CONFIG, config_word(cur_code, cur_ena, cur_odd, cur_two),
				"config after busy writes");
		end
	endtask

	initial begin
		int c;
		int v;
		seed = 32'hdfa5_a587;
		reset = 1'b1;
		cs_addr = REG_PDU_SIZE;
		cs_wr = 1'b0;
		cs_wrd = '0;
		pdu_addr = 2'd0;
		pdu_wr = 1'b0;
		pdu_wrd = '0;
		cur_code = 2'd1;	// reset config is 19200 even
		cur_ena = 1'b1;
		cur_odd = 1'b0;
		cur_two = 1'b0;
		cur_div = bit_clocks(2'd1);
		cur_addr = 8'd1;
		cur_size = 1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		set_size(6);	// default frame
		load_pdu();
		send_frame(1'b0);

		read_check(REG_PDU_SIZE, 32'd6, "pdu_size");	// readback and range checks
		reg_write(REG_PDU_SIZE, 32'd0);
		read_check(REG_PDU_SIZE, 32'd6, "pdu_size after size 0");
		reg_write(REG_PDU_SIZE, 32'd17);
		read_check(REG_PDU_SIZE, 32'd6, "pdu_size after size 17");
		set_config(2'd2, 1'b0, 1'b1, 1'b1);
		read_check(REG_CONFIG, config_word(2'd2, 1'b0, 1'b1, 1'b1), "config");
		set_addr(8'd247);
		read_check(REG_SLAVE_ADDR, 32'd247, "slave_addr");
		reg_write(REG_SLAVE_ADDR, 32'd248);
		read_check(REG_SLAVE_ADDR, 32'd247, "slave_addr after 248");
		read_check(REG_CONTROL, 32'd1, "ready status");

		set_addr(8'd17);	// line options at slow and fast rates
		set_size(3);
		load_pdu();
		for (c = 0; c < 2; c++) begin
			for (v = 0; v < 4; v++) begin
				set_config((c == 0) ? 2'd0 : 2'd3, (v == 0) || (v == 3), v == 0, v >= 2);
				send_frame(1'b0);
			end
		end

		set_config(2'd1, 1'b1, 1'b0, 1'b0);	// writes while busy
		set_size(4);
		load_pdu();
		send_frame(1'b1);

		set_addr(8'd0);	// broadcast with smallest pdu
		set_size(1);
		load_pdu();
		send_frame(1'b0);
		set_addr(8'd5);	// full buffer
		set_size(MAX_PDU_SIZE);
		load_pdu();
		send_frame(1'b0);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: sources.f
hw/rtu_pkg.sv
hw/rtu_regs.sv
hw/frame_buffer.sv
hw/crc16_engine.sv
hw/rtu_timer.sv
hw/rtu_master_fsm.sv
hw/uart_tx.sv
hw/rtu_tx_master.sv
sim/rtu_tx_master_properties.sv
sim/rtu_tx_master_tb.sv

// File: Bender.yml
package:
  name: rtu_tx_master

sources:
  - files:
      - hw/rtu_pkg.sv
      - hw/rtu_regs.sv
      - hw/frame_buffer.sv
      - hw/crc16_engine.sv
      - hw/rtu_timer.sv
      - hw/rtu_master_fsm.sv
      - hw/uart_tx.sv
      - hw/rtu_tx_master.sv
  - target: simulation
    files:
      - sim/rtu_tx_master_properties.sv
      - sim/rtu_tx_master_tb.sv
